/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data and address width of the core
    parameter int xlen_w = 32;

    // RISC-V load/store funct3 codes
    typedef enum logic [2:0] {
        f3_lb  = 3'b000,
        f3_lh  = 3'b001,
        f3_lw  = 3'b010,
        f3_lbu = 3'b100,
        f3_lhu = 3'b101
    } lsu_funct3_t;

    // stores share the load codes, qualified by the store flag
    parameter lsu_funct3_t f3_sb = f3_lb;
    parameter lsu_funct3_t f3_sh = f3_lh;
    parameter lsu_funct3_t f3_sw = f3_lw;

    // access size in funct3[1:0]
    parameter logic [1:0] size_byte = 2'b00;
    parameter logic [1:0] size_half = 2'b01;
    parameter logic [1:0] size_word = 2'b10;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // decoded operation, decode to execute
    typedef struct packed {
        logic              is_store;
        lsu_funct3_t       funct3;
        logic [1:0]        byte_offset;
        logic [xlen_w-1:0] addr;
        logic [xlen_w-1:0] wdata;
        logic [3:0]        wstrb;
        logic              misaligned;
        logic [4:0]        rd;
    } lsu_op_t;

    // raw bus result, execute to result
    typedef struct packed {
        logic [xlen_w-1:0] rdata;
        axi_resp_t         resp;
        logic              misaligned;
        logic              is_store;
        lsu_funct3_t       funct3;
        logic [1:0]        byte_offset;
        logic [4:0]        rd;
    } lsu_raw_t;

endpackage

`default_nettype wire

/* axi_lite_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface axi_lite_if;
    import lsu_pkg::*;

    // write address and data
    logic [xlen_w-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [xlen_w-1:0] wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;

    // write response
    axi_resp_t         bresp;
    logic              bvalid;
    logic              bready;

    // read address and data
    logic [xlen_w-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [xlen_w-1:0] rdata;
    axi_resp_t         rresp;
    logic              rvalid;
    logic              rready;

    modport master (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

    modport slave (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
        output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

/* lsu_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_decode (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               req_valid,
    output logic                              req_ready,
    input  wire                               req_store,
    input  wire lsu_pkg::lsu_funct3_t         req_funct3,
    input  wire [lsu_pkg::xlen_w-1:0]         req_base,
    input  wire [lsu_pkg::xlen_w-1:0]         req_offset,
    input  wire [lsu_pkg::xlen_w-1:0]         req_wdata,
    input  wire [4:0]                         req_rd,
    input  wire                               busy,
    output logic                              op_valid,
    input  wire                               op_ready,
    output lsu_pkg::lsu_op_t                  op
);
    import lsu_pkg::*;

    lsu_op_t     next_op;
    logic [31:0] addr;
    logic [1:0]  offset;

    // only one operation in the whole unit at a time
    assign req_ready = !busy && !op_valid;

    assign addr   = req_base + req_offset;
    assign offset = addr[1:0];

    always_comb begin
        next_op.is_store    = req_store;
        next_op.funct3      = req_funct3;
        next_op.byte_offset = offset;
        next_op.addr        = addr;
        next_op.rd          = req_rd;
        // move store data into the addressed byte lane
        next_op.wdata       = req_wdata << {offset, 3'b000};
        case (req_funct3[1:0])
            size_byte: begin
                next_op.wstrb      = 4'b0001 << offset;
                next_op.misaligned = 1'b0;
            end
            size_half: begin
                next_op.wstrb      = 4'b0011 << offset;
                next_op.misaligned = addr[0];
            end
            default: begin
                next_op.wstrb      = 4'b1111;
                next_op.misaligned = |addr[1:0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (req_valid && req_ready) begin
            op_valid <= 1'b1;
        end else if (op_ready) begin
            op_valid <= 1'b0;
        end
    end

    // payload register, loaded on accept
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op <= next_op;
        end
    end

    // held op is not disturbed while execute stalls
    a_op_stable: assert property (@(posedge clk) disable iff (rst)
        op_valid && !op_ready |=> op_valid && $stable(op));

endmodule

`default_nettype wire

/* lsu_axi_master.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_axi_master (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    op_valid,
    output logic                   op_ready,
    input  wire lsu_pkg::lsu_op_t  op,
    output logic                   raw_valid,
    input  wire                    raw_ready,
    output lsu_pkg::lsu_raw_t      raw,
    output logic                   busy,
    axi_lite_if.master             axi
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write,
        st_hold
    } state_t;

    state_t      state;
    lsu_op_t     op_q;
    logic [31:0] rdata_q;
    axi_resp_t   resp_q;
    logic        ar_done;
    logic        aw_done;
    logic        w_done;

    assign op_ready  = (state == st_idle);
    assign raw_valid = (state == st_hold);
    assign busy      = (state != st_idle);

    // bus addresses are always word aligned, lanes come from the strobe
    assign axi.araddr  = {op_q.addr[31:2], 2'b00};
    assign axi.arvalid = (state == st_read) && !ar_done;
    assign axi.rready  = (state == st_read);
    assign axi.awaddr  = {op_q.addr[31:2], 2'b00};
    assign axi.awvalid = (state == st_write) && !aw_done;
    assign axi.wdata   = op_q.wdata;
    assign axi.wstrb   = op_q.wstrb;
    assign axi.wvalid  = (state == st_write) && !w_done;
    assign axi.bready  = (state == st_write);

    assign raw = '{rdata: rdata_q, resp: resp_q, misaligned: op_q.misaligned,
                   is_store: op_q.is_store, funct3: op_q.funct3,
                   byte_offset: op_q.byte_offset, rd: op_q.rd};

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            ar_done <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    ar_done <= 1'b0;
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (op_valid) begin
                        // misaligned ops never touch the bus
                        if (op.misaligned) begin
                            state <= st_hold;
                        end else if (op.is_store) begin
                            state <= st_write;
                        end else begin
                            state <= st_read;
                        end
                    end
                end
                st_read: begin
                    if (axi.arvalid && axi.arready) begin
                        ar_done <= 1'b1;
                    end
                    if (axi.rvalid) begin
                        state <= st_hold;
                    end
                end
                st_write: begin
                    // aw and w may complete in either order
                    if (axi.awvalid && axi.awready) begin
                        aw_done <= 1'b1;
                    end
                    if (axi.wvalid && axi.wready) begin
                        w_done <= 1'b1;
                    end
                    if (axi.bvalid) begin
                        state <= st_hold;
                    end
                end
                default: begin
                    if (raw_ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && op_valid) begin
            op_q    <= op;
            rdata_q <= '0;
            resp_q  <= resp_okay;
        end else if (state == st_read && axi.rvalid) begin
            rdata_q <= axi.rdata;
            resp_q  <= axi.rresp;
        end else if (state == st_write && axi.bvalid) begin
            resp_q  <= axi.bresp;
        end
    end

    a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
        !(axi.awvalid && axi.arvalid));

    a_wvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi.wvalid && !axi.wready |=> axi.wvalid);

endmodule

`default_nettype wire

/* lsu_result.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_result (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     raw_valid,
    output logic                    raw_ready,
    input  wire lsu_pkg::lsu_raw_t  raw,
    output logic                    rsp_valid,
    input  wire                     rsp_ready,
    output logic [lsu_pkg::xlen_w-1:0] rsp_data,
    output logic [4:0]              rsp_rd,
    output logic                    rsp_err,
    output logic                    busy
);
    import lsu_pkg::*;

    logic [31:0] lane;
    logic [31:0] load_data;

    // a held response blocks the next raw record
    assign raw_ready = !rsp_valid;
    assign busy      = rsp_valid;

    // addressed byte or half moved down to bit 0
    assign lane = raw.rdata >> {raw.byte_offset, 3'b000};

    always_comb begin
        case (raw.funct3)
            f3_lb:   load_data = {{24{lane[7]}}, lane[7:0]};
            f3_lh:   load_data = {{16{lane[15]}}, lane[15:0]};
            f3_lbu:  load_data = {24'h0, lane[7:0]};
            f3_lhu:  load_data = {16'h0, lane[15:0]};
            default: load_data = raw.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (raw_valid && raw_ready) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid && raw_ready) begin
            rsp_data <= raw.is_store ? '0 : load_data;
            rsp_rd   <= raw.rd;
            rsp_err  <= raw.misaligned || (raw.resp != resp_okay);
        end
    end

endmodule

`default_nettype wire

/* sram_axi_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module sram_axi_slave #(
    parameter logic [31:0] mem_base  = 32'h8000_0000,
    parameter int          mem_words = 256
) (
    input  wire        clk,
    input  wire        rst,
    axi_lite_if.slave  axi
);
    import lsu_pkg::*;

    localparam int          idx_w     = $clog2(mem_words);
    localparam logic [31:0] mem_bytes = 32'(mem_words) * 32'd4;

    logic [31:0] mem [mem_words];

    logic        aw_held;
    logic        w_held;
    logic [31:0] awaddr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;

    logic        aw_ok;
    logic        w_ok;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic [31:0] wr_off;
    logic [31:0] rd_off;
    logic        wr_hit;
    logic        rd_hit;

    // read channel, one beat per AR
    assign axi.arready = !axi.rvalid;
    assign rd_off      = axi.araddr - mem_base;
    assign rd_hit      = rd_off < mem_bytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            axi.rvalid <= 1'b0;
        end else if (axi.arvalid && axi.arready) begin
            axi.rvalid <= 1'b1;
        end else if (axi.rready) begin
            axi.rvalid <= 1'b0;
        end
    end

    // out of range reads give zero data
    always_ff @(posedge clk) begin
        if (axi.arvalid && axi.arready) begin
            axi.rdata <= rd_hit ? mem[rd_off[idx_w+1:2]] : '0;
            axi.rresp <= rd_hit ? resp_okay : resp_slverr;
        end
    end

    // write side, aw and w latched on their own
    assign axi.awready = !aw_held;
    assign axi.wready  = !w_held;

    assign aw_ok   = aw_held || axi.awvalid;
    assign w_ok    = w_held || axi.wvalid;
    assign wr_addr = aw_held ? awaddr_q : axi.awaddr;
    assign wr_data = w_held ? wdata_q : axi.wdata;
    assign wr_strb = w_held ? wstrb_q : axi.wstrb;
    assign wr_off  = wr_addr - mem_base;
    assign wr_hit  = wr_off < mem_bytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held    <= 1'b0;
            w_held     <= 1'b0;
            axi.bvalid <= 1'b0;
        end else if (axi.bvalid) begin
            if (axi.bready) begin
                aw_held    <= 1'b0;
                w_held     <= 1'b0;
                axi.bvalid <= 1'b0;
            end
        end else begin
            if (axi.awvalid && axi.awready) begin
                aw_held <= 1'b1;
            end
            if (axi.wvalid && axi.wready) begin
                w_held <= 1'b1;
            end
            // both halves present, respond next cycle
            if (aw_ok && w_ok) begin
                axi.bvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (axi.awvalid && axi.awready) begin
            awaddr_q <= axi.awaddr;
        end
        if (axi.wvalid && axi.wready) begin
            wdata_q <= axi.wdata;
            wstrb_q <= axi.wstrb;
        end
        if (!axi.bvalid && aw_ok && w_ok) begin
            axi.bresp <= wr_hit ? resp_okay : resp_slverr;
            if (wr_hit) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_off[idx_w+1:2]][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi.rvalid && !axi.rready |=> axi.rvalid);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        axi.bvalid && !axi.bready |=> axi.bvalid);

endmodule

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
    parameter logic [31:0] mem_base  = 32'h8000_0000,
    parameter int          mem_words = 256
) (
    input  wire                          clk,
    input  wire                          rst,
    // request from the pipeline
    input  wire                          req_valid,
    output logic                         req_ready,
    input  wire                          req_store,
    input  wire lsu_pkg::lsu_funct3_t    req_funct3,
    input  wire [lsu_pkg::xlen_w-1:0]    req_base,
    input  wire [lsu_pkg::xlen_w-1:0]    req_offset,
    input  wire [lsu_pkg::xlen_w-1:0]    req_wdata,
    input  wire [4:0]                    req_rd,
    // response to the pipeline
    output logic                         rsp_valid,
    input  wire                          rsp_ready,
    output logic [lsu_pkg::xlen_w-1:0]   rsp_data,
    output logic [4:0]                   rsp_rd,
    output logic                         rsp_err
);
    import lsu_pkg::*;

    lsu_op_t  op;
    logic     op_valid;
    logic     op_ready;
    lsu_raw_t raw;
    logic     raw_valid;
    logic     raw_ready;
    logic     master_busy;
    logic     result_busy;
    logic     busy;

    axi_lite_if axi_bus ();

    // anything past decode blocks new requests
    assign busy = master_busy || result_busy;

    lsu_decode i_lsu_decode (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_store  (req_store),
        .req_funct3 (req_funct3),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .busy       (busy),
        .op_valid   (op_valid),
        .op_ready   (op_ready),
        .op         (op)
    );

    lsu_axi_master i_lsu_axi_master (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op        (op),
        .raw_valid (raw_valid),
        .raw_ready (raw_ready),
        .raw       (raw),
        .busy      (master_busy),
        .axi       (axi_bus.master)
    );

    lsu_result i_lsu_result (
        .clk       (clk),
        .rst       (rst),
        .raw_valid (raw_valid),
        .raw_ready (raw_ready),
        .raw       (raw),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_rd    (rsp_rd),
        .rsp_err   (rsp_err),
        .busy      (result_busy)
    );

    sram_axi_slave #(
        .mem_base  (mem_base),
        .mem_words (mem_words)
    ) i_sram_axi_slave (
        .clk (clk),
        .rst (rst),
        .axi (axi_bus.slave)
    );

endmodule

`default_nettype wire

/* tb_lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam logic [31:0] mem_base       = 32'h8000_0000;
    localparam int          mem_words      = 256;
    localparam logic [31:0] mem_bytes      = 32'(4 * mem_words);
    localparam int          reset_cycles   = 3;
    localparam int          n_random       = 200;
    // 16 fill stores, 26 directed accesses, then the random run
    localparam int          n_requests     = 16 + 26 + n_random;
    localparam int          timeout_cycles = 40 * n_requests + reset_cycles;
    localparam logic [31:0] lfsr_taps      = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    logic        req_store;
    lsu_funct3_t req_funct3;
    logic [31:0] req_base;
    logic [31:0] req_offset;
    logic [31:0] req_wdata;
    logic [4:0]  req_rd;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_data;
    logic [4:0]  rsp_rd;
    logic        rsp_err;

    // expected entry for the response in flight
    logic [31:0] exp_data = '0;
    logic [4:0]  exp_rd   = '0;
    logic        exp_err  = 1'b0;

    logic [7:0]  model_mem [4*mem_words];
    logic [31:0] lfsr_state   = 32'd69477;
    logic        random_stall = 1'b0;
    int          cycles       = 0;

    lsu_top #(
        .mem_base  (mem_base),
        .mem_words (mem_words)
    ) i_lsu_top (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_store  (req_store),
        .req_funct3 (req_funct3),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_wdata  (req_wdata),
        .req_rd     (req_rd),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .rsp_rd     (rsp_rd),
        .rsp_err    (rsp_err)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            report_error("timeout, the run did not finish within its cycle limit");
        end
    end

    // galois lfsr, one step per bit
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ lfsr_taps;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic lsu_funct3_t load_code(input logic [2:0] sel);
        case (sel)
            3'd0:    return f3_lb;
            3'd1:    return f3_lh;
            3'd2:    return f3_lw;
            3'd3:    return f3_lbu;
            3'd4:    return f3_lhu;
            3'd5:    return f3_lw;
            3'd6:    return f3_lbu;
            default: return f3_lhu;
        endcase
    endfunction

    function automatic lsu_funct3_t store_code(input logic [1:0] sel);
        case (sel)
            2'd0:    return f3_sb;
            2'd1:    return f3_sh;
            default: return f3_sw;
        endcase
    endfunction

    // one request, then wait for its response
    task automatic run_access(input logic store, input lsu_funct3_t f3,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [4:0] rd, input int hold);
        logic [31:0] offset_v;
        logic [31:0] off;
        logic [31:0] value;
        logic [1:0]  align_mask;
        logic        taken;
        int          size;
        int          held;
        int          bi;

        size       = 1 << f3[1:0];
        align_mask = 2'(size - 1);
        off        = addr - mem_base;
        exp_rd     = rd;
        exp_err    = ((addr[1:0] & align_mask) != 2'b00) || !(off < mem_bytes);
        exp_data   = '0;
        if (!store && !exp_err) begin
            // little endian gather, then extend by funct3
            value = '0;
            for (int i = 0; i < size; i++) begin
                bi = int'(off) + i;
                value[8*i +: 8] = model_mem[bi];
            end
            if (!f3[2] && value[8*size-1]) begin
                for (int i = size; i < 4; i++) begin
                    value[8*i +: 8] = 8'hff;
                end
            end
            exp_data = value;
        end
        if (store && !exp_err) begin
            for (int i = 0; i < size; i++) begin
                bi = int'(off) + i;
                model_mem[bi] = wdata[8*i +: 8];
            end
        end

        // random signed split of the address into base and offset
        offset_v = rand_bits(8);
        offset_v = {{24{offset_v[7]}}, offset_v[7:0]};

        req_valid  = 1'b1;
        req_store  = store;
        req_funct3 = f3;
        req_base   = addr - offset_v;
        req_offset = offset_v;
        req_wdata  = wdata;
        req_rd     = rd;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;

        taken = 1'b0;
        held  = 0;
        while (!taken) begin
            if (rsp_valid && held < hold) begin
                rsp_ready = 1'b0;
                held++;
            end else if (random_stall) begin
                // stall roughly one cycle in four
                rsp_ready = rand_bits(2) != 32'd3;
            end else begin
                rsp_ready = 1'b1;
            end
            taken = rsp_valid && rsp_ready;
            @(negedge clk);
        end
        rsp_ready = 1'b0;
    endtask

    a_rsp_data: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_data == exp_data)
        else report_mismatch("rsp_data", rsp_data, exp_data);

    a_rsp_rd: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_rd == exp_rd)
        else report_mismatch("rsp_rd", {27'd0, rsp_rd}, {27'd0, exp_rd});

    a_rsp_err: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && rsp_ready |-> rsp_err == exp_err)
        else report_mismatch("rsp_err", {31'd0, rsp_err}, {31'd0, exp_err});

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data) && $stable(rsp_rd)
            && $stable(rsp_err))
        else report_error("response changed or dropped while rsp_ready was low");

    a_no_accept_while_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> !req_ready)
        else report_error("req_ready was high while a response was still held");

    initial begin
        logic [31:0] addr_r;
        logic        store_r;
        lsu_funct3_t f3_r;

        rst        = 1'b1;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_funct3 = f3_lb;
        req_base   = '0;
        req_offset = '0;
        req_wdata  = '0;
        req_rd     = '0;
        rsp_ready  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        assert (req_ready == 1'b1)
            else report_mismatch("req_ready", {31'd0, req_ready}, 32'h1);
        assert (rsp_valid == 1'b0)
            else report_mismatch("rsp_valid", {31'd0, rsp_valid}, 32'h0);

        // fill the first 16 words so no load sees undefined data
        for (int w = 0; w < 16; w++) begin
            run_access(1'b1, f3_sw, mem_base + 32'(4 * w), rand_bits(32), 5'(w), 0);
        end

        // word store and load back
        run_access(1'b1, f3_sw, mem_base + 32'h20, 32'hdead_beef, 5'd1, 0);
        run_access(1'b0, f3_lw, mem_base + 32'h20, 32'h0, 5'd7, 0);
        run_access(1'b1, f3_sw, mem_base + 32'h24, 32'h0123_4567, 5'd2, 0);
        run_access(1'b0, f3_lw, mem_base + 32'h24, 32'h0, 5'd31, 0);

        // byte and half lanes, sign and zero extension
        run_access(1'b1, f3_sw, mem_base + 32'h28, 32'h1122_3344, 5'd3, 0);
        run_access(1'b1, f3_sb, mem_base + 32'h29, 32'h0000_0080, 5'd4, 0);
        run_access(1'b1, f3_sh, mem_base + 32'h2a, 32'h0000_beef, 5'd5, 0);
        run_access(1'b0, f3_lw, mem_base + 32'h28, 32'h0, 5'd6, 0);
        run_access(1'b0, f3_lb, mem_base + 32'h29, 32'h0, 5'd8, 0);
        run_access(1'b0, f3_lbu, mem_base + 32'h29, 32'h0, 5'd9, 0);
        run_access(1'b0, f3_lh, mem_base + 32'h2a, 32'h0, 5'd10, 0);
        run_access(1'b0, f3_lhu, mem_base + 32'h2a, 32'h0, 5'd11, 0);
        run_access(1'b0, f3_lb, mem_base + 32'h28, 32'h0, 5'd12, 0);
        run_access(1'b0, f3_lh, mem_base + 32'h28, 32'h0, 5'd13, 0);

        // misaligned accesses stay off the bus
        run_access(1'b0, f3_lh, mem_base + 32'h29, 32'h0, 5'd14, 0);
        run_access(1'b0, f3_lw, mem_base + 32'h2a, 32'h0, 5'd15, 0);
        run_access(1'b1, f3_sw, mem_base + 32'h29, 32'hffff_ffff, 5'd16, 0);
        run_access(1'b1, f3_sh, mem_base + 32'h2b, 32'h0000_ffff, 5'd17, 0);
        run_access(1'b0, f3_lw, mem_base + 32'h28, 32'h0, 5'd18, 0);

        // outside the sram window
        run_access(1'b0, f3_lw, mem_base + mem_bytes, 32'h0, 5'd19, 0);
        run_access(1'b1, f3_sw, mem_base + mem_bytes, 32'h5a5a_5a5a, 5'd20, 0);
        run_access(1'b0, f3_lb, mem_base - 32'h1, 32'h0, 5'd21, 0);
        run_access(1'b0, f3_lw, 32'h9000_0000, 32'h0, 5'd22, 0);
        run_access(1'b0, f3_lw, mem_base, 32'h0, 5'd23, 0);

        // long rsp_ready stalls
        run_access(1'b0, f3_lw, mem_base + 32'h20, 32'h0, 5'd24, 6);
        run_access(1'b1, f3_sb, mem_base + 32'h30, 32'h0000_00a5, 5'd25, 4);

        random_stall = 1'b1;
        for (int n = 0; n < n_random; n++) begin
            if (rand_bits(4) == 32'd0) begin
                addr_r = mem_base + mem_bytes + rand_bits(8);
            end else begin
                addr_r = mem_base + rand_bits(6);
            end
            store_r = rand_bits(1) != 32'd0;
            if (store_r) begin
                f3_r = store_code(2'(rand_bits(2)));
            end else begin
                f3_r = load_code(3'(rand_bits(3)));
            end
            run_access(store_r, f3_r, addr_r, rand_bits(32), 5'(rand_bits(5)), 0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
lsu_pkg.sv
axi_lite_if.sv
lsu_decode.sv
lsu_axi_master.sv
lsu_result.sv
sram_axi_slave.sv
lsu_top.sv
tb_lsu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module tb_lsu_top \
        -Mdir obj_dir -o tb_lsu_top -f compile.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_lsu_top > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "TESTBENCH PASSED" "$log"; then
    exit 0
fi
exit 1
